// File: project.f
+incdir+rtl
+incdir+tests
rtl/hazard_pkg.sv
rtl/instrClassifier.sv
rtl/forwardSelect.sv
rtl/stallControl.sv
rtl/hazardUnit.sv
tests/hazardUnit_tb.sv

// File: rtl/forwardSelect.sv
`timescale 1ns/1ps

module forwardSelect #(
	parameter hazard_pkg::stage_t nearest = hazard_pkg::stE // Earliest stage allowed to forward
) (
	input  hazard_pkg::regAddr_t   regNum,
	input  logic                   useOp,
	input  hazard_pkg::stageInfo_t infoE,
	input  hazard_pkg::stageInfo_t infoM,
	input  hazard_pkg::stageInfo_t infoW,
	output hazard_pkg::fwdSel_t    sel
);
	import hazard_pkg::*;

	localparam bit allowE = nearest == stE;
	localparam bit allowM = nearest != stW;

	function automatic logic hits(
		input stageInfo_t info,
		input provider_t kind,
		input regAddr_t num
	);
		return info.prov == kind && info.dest == num;
	endfunction

	always_comb
	begin
		sel = fwdNone;
		if (useOp && regNum != '0) // $zero always reads the file
		begin
			if (allowE && hits(infoE, provLink, regNum))
				sel = fwdELink;
			else if (allowM && hits(infoM, provLink, regNum))
				sel = fwdMLink;
			else if (hits(infoW, provLink, regNum))
				sel = fwdWLink;
			else if (allowE && hits(infoE, provAlu, regNum))
				sel = fwdEAlu;
			else if (allowM && hits(infoM, provAlu, regNum))
				sel = fwdMAlu;
			else if (hits(infoW, provAlu, regNum))
				sel = fwdWAlu;
			else if (hits(infoW, provMem, regNum))
				sel = fwdWMem; // Load data only exists from W
		end
	end

endmodule

// File: rtl/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
	input  logic                   clk,
	input  logic                   rstN,
	input  hazard_pkg::instrWord_t instrD,
	input  hazard_pkg::instrWord_t instrE,
	input  hazard_pkg::instrWord_t instrM,
	input  hazard_pkg::instrWord_t instrW,
	input  logic                   branchOk,
	input  logic                   intReq,
	input  logic                   run,
	output hazard_pkg::fwdSel_t    selPcReg,
	output hazard_pkg::fwdSel_t    selCmpA,
	output hazard_pkg::fwdSel_t    selCmpB,
	output hazard_pkg::fwdSel_t    selAluA,
	output hazard_pkg::fwdSel_t    selAluB,
	output hazard_pkg::fwdSel_t    selStoreE,
	output hazard_pkg::fwdSel_t    selStoreM,
	output hazard_pkg::pipeCtrl_t  ctrl,
	output logic                   exlSet,
	output logic                   exlClr
);
	import hazard_pkg::*;

	stageInfo_t infoD;
	stageInfo_t infoE;
	stageInfo_t infoM;
	stageInfo_t infoW;

	instrClassifier uClassD (.instr(instrD), .info(infoD));
	instrClassifier uClassE (.instr(instrE), .info(infoE));
	instrClassifier uClassM (.instr(instrM), .info(infoM));
	instrClassifier uClassW (.instr(instrW), .info(infoW));

	// Consumers in D
	forwardSelect #(.nearest(stE)) uFwdPcReg (
		.regNum(infoD.rs), .useOp(infoD.isJumpReg),
		.infoE(infoE), .infoM(infoM), .infoW(infoW), .sel(selPcReg)
	);
	forwardSelect #(.nearest(stE)) uFwdCmpA (
		.regNum(infoD.rs), .useOp(infoD.isBranchOne || infoD.isBranchTwo),
		.infoE(infoE), .infoM(infoM), .infoW(infoW), .sel(selCmpA)
	);
	forwardSelect #(.nearest(stE)) uFwdCmpB (
		.regNum(infoD.rt), .useOp(infoD.isBranchTwo),
		.infoE(infoE), .infoM(infoM), .infoW(infoW), .sel(selCmpB)
	);

	// Consumers in E
	forwardSelect #(.nearest(stM)) uFwdAluA (
		.regNum(infoE.rs), .useOp(infoE.useRs),
		.infoE(infoE), .infoM(infoM), .infoW(infoW), .sel(selAluA)
	);
	forwardSelect #(.nearest(stM)) uFwdAluB (
		.regNum(infoE.rt), .useOp(infoE.useRt),
		.infoE(infoE), .infoM(infoM), .infoW(infoW), .sel(selAluB)
	);

	// Store data only takes W results
	forwardSelect #(.nearest(stW)) uFwdStoreE (
		.regNum(infoE.rt), .useOp(infoE.isStore),
		.infoE(infoE), .infoM(infoM), .infoW(infoW), .sel(selStoreE)
	);
	forwardSelect #(.nearest(stW)) uFwdStoreM (
		.regNum(infoM.rt), .useOp(infoM.isStore),
		.infoE(infoE), .infoM(infoM), .infoW(infoW), .sel(selStoreM)
	);

	stallControl uStall (
		.clk(clk),
		.rstN(rstN),
		.infoD(infoD),
		.infoE(infoE),
		.infoM(infoM),
		.branchOk(branchOk),
		.intReq(intReq),
		.run(run),
		.ctrl(ctrl),
		.exlSet(exlSet),
		.exlClr(exlClr)
	);

endmodule

// File: rtl/hazard_config.svh
`ifndef HAZARD_CONFIG_SVH
`define HAZARD_CONFIG_SVH

`define INSTR_WIDTH    32
`define REG_ADDR_WIDTH 5
`define FWD_SEL_WIDTH  4

`define LINK_REG 31 // Written by jal

`define OP_RTYPE  0
`define OP_REGIMM 1 // bltz, bgez
`define OP_J      2
`define OP_JAL    3
`define OP_BEQ    4
`define OP_BNE    5
`define OP_BLEZ   6
`define OP_BGTZ   7
`define OP_ADDI   8
`define OP_ADDIU  9
`define OP_ANDI   12
`define OP_ORI    13
`define OP_XORI   14
`define OP_LUI    15
`define OP_COP0   16
`define OP_LW     35
`define OP_SW     43

`define FN_JR   8
`define FN_JALR 9
`define FN_ERET 24 // Under OP_COP0

`endif

// File: rtl/hazard_pkg.sv
`include "hazard_config.svh"

package hazard_pkg;

	typedef logic [`INSTR_WIDTH-1:0] instrWord_t;
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;

	// What a stage will write back to the register file
	typedef enum logic [1:0] {
		provNone,
		provAlu,
		provMem,
		provLink
	} provider_t;

	typedef enum logic [1:0] {
		stE,
		stM,
		stW
	} stage_t;

	typedef enum logic [`FWD_SEL_WIDTH-1:0] {
		fwdNone  = 0, // Register file value
		fwdELink = 1,
		fwdMLink = 2,
		fwdWLink = 3,
		fwdEAlu  = 4,
		fwdMAlu  = 5,
		fwdWAlu  = 6,
		fwdWMem  = 7
	} fwdSel_t;

	typedef struct packed {
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t dest; // Zero when nothing is written
		provider_t prov;
		logic useRs; // ALU operand A
		logic useRt; // ALU operand B
		logic isBranchTwo;
		logic isBranchOne;
		logic isJumpReg;
		logic isJump;
		logic isLoad;
		logic isStore;
		logic isEret;
	} stageInfo_t;

	typedef struct packed {
		logic pcWrite;
		logic writeD;
		logic writeE;
		logic writeM;
		logic flushD;
		logic flushE;
		logic flushM;
	} pipeCtrl_t;

endpackage

// File: rtl/instrClassifier.sv
`timescale 1ns/1ps
`include "hazard_config.svh"

module instrClassifier (
	input  hazard_pkg::instrWord_t instr,
	output hazard_pkg::stageInfo_t info
);
	import hazard_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t rd;

	logic rtype;
	logic rtypeAlu;
	logic immAlu;
	logic load;
	logic store;
	logic jal;
	logic jalr;
	logic jr;

	assign opcode = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign funct = instr[5:0];

	assign rtype = opcode == `OP_RTYPE;
	assign jr = rtype && funct == `FN_JR;
	assign jalr = rtype && funct == `FN_JALR;
	assign rtypeAlu = rtype && !jr && !jalr; // Shifts and nop land here too
	assign immAlu = opcode == `OP_ADDI || opcode == `OP_ADDIU || opcode == `OP_ANDI
		|| opcode == `OP_ORI || opcode == `OP_XORI || opcode == `OP_LUI;
	assign load = opcode == `OP_LW;
	assign store = opcode == `OP_SW;
	assign jal = opcode == `OP_JAL;

	always_comb
	begin
		info = '0;
		info.rs = rs;
		info.rt = rt;
		info.isBranchTwo = opcode == `OP_BEQ || opcode == `OP_BNE;
		info.isBranchOne = opcode == `OP_BLEZ || opcode == `OP_BGTZ || opcode == `OP_REGIMM;
		info.isJumpReg = jr || jalr;
		info.isJump = opcode == `OP_J || jal;
		info.isLoad = load;
		info.isStore = store;
		info.isEret = opcode == `OP_COP0 && funct == `FN_ERET;
		info.useRs = rtypeAlu || immAlu || load || store; // Base address for memory ops
		info.useRt = rtypeAlu;

		if (rtypeAlu)
		begin
			info.dest = rd;
			info.prov = provAlu;
		end
		else if (immAlu)
		begin
			info.dest = rt;
			info.prov = provAlu;
		end
		else if (load)
		begin
			info.dest = rt;
			info.prov = provMem;
		end
		else if (jal)
		begin
			info.dest = regAddr_t'(`LINK_REG);
			info.prov = provLink;
		end
		else if (jalr)
		begin
			info.dest = rd;
			info.prov = provLink;
		end
	end

endmodule

// File: rtl/stallControl.sv
`timescale 1ns/1ps

module stallControl (
	input  logic                   clk,
	input  logic                   rstN,
	input  hazard_pkg::stageInfo_t infoD,
	input  hazard_pkg::stageInfo_t infoE,
	input  hazard_pkg::stageInfo_t infoM,
	input  logic                   branchOk,
	input  logic                   intReq,
	input  logic                   run,
	output hazard_pkg::pipeCtrl_t  ctrl,
	output logic                   exlSet,
	output logic                   exlClr
);
	import hazard_pkg::*;

	logic exl; // Inside the handler, no nesting
	logic needRsD;
	logic needRtD;
	logic execStall;
	logic decodeStall;
	logic hazardE;
	logic hazardM;
	logic redirect;

	function automatic logic regHit(input regAddr_t src, input regAddr_t dst);
		return src != '0 && src == dst;
	endfunction

	// Load result in M arrives too late for the ALU in E
	assign execStall = infoM.isLoad
		&& ((infoE.useRs && regHit(infoE.rs, infoM.dest))
		|| (infoE.useRt && regHit(infoE.rt, infoM.dest)));

	// Branch compare and jr target resolve in D
	assign needRsD = infoD.isBranchOne || infoD.isBranchTwo || infoD.isJumpReg;
	assign needRtD = infoD.isBranchTwo;

	assign hazardE = infoE.prov != provNone
		&& ((needRsD && regHit(infoD.rs, infoE.dest))
		|| (needRtD && regHit(infoD.rt, infoE.dest)));
	assign hazardM = infoM.isLoad
		&& ((needRsD && regHit(infoD.rs, infoM.dest))
		|| (needRtD && regHit(infoD.rt, infoM.dest)));
	assign decodeStall = hazardE || hazardM;

	assign redirect = ((infoD.isBranchOne || infoD.isBranchTwo) && branchOk)
		|| infoD.isJump || infoD.isJumpReg;

	always_comb
	begin
		ctrl = '0;
		exlSet = 1'b0;
		exlClr = 1'b0;
		if (run) // Low freezes every stage
		begin
			ctrl.pcWrite = 1'b1;
			ctrl.writeD = 1'b1;
			ctrl.writeE = 1'b1;
			ctrl.writeM = 1'b1;
			if (execStall)
			begin
				ctrl.pcWrite = 1'b0;
				ctrl.writeD = 1'b0;
				ctrl.writeE = 1'b0;
				ctrl.flushM = 1'b1; // Bubble into M
			end
			else if (decodeStall)
			begin
				ctrl.pcWrite = 1'b0;
				ctrl.writeD = 1'b0;
				ctrl.flushE = 1'b1;
			end
			else if (redirect)
			begin
				ctrl.flushD = 1'b0;
			end
			else if (infoD.isEret)
			begin
				ctrl.flushD = 1'b1;
				exlClr = 1'b1;
			end
			else if (intReq && !exl)
			begin
				ctrl.flushD = 1'b1; // Drop the instruction after the interrupt point
				exlSet = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			exl <= 1'b0;
		else if (exlSet)
			exl <= 1'b1;
		else if (exlClr)
			exl <= 1'b0;
	end

	setClrExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(exlSet && exlClr))
		else $error("stallControl: exlSet and exlClr together");

	flushNotHeld: assert property (@(posedge clk) disable iff (!rstN)
		(!ctrl.flushD || ctrl.writeD) && (!ctrl.flushE || ctrl.writeE)
		&& (!ctrl.flushM || ctrl.writeM))
		else $error("stallControl: flush on a held stage %b", ctrl);

	// One entry per eret, and the flag follows on the next edge
	noNestedInt: assert property (@(posedge clk) disable iff (!rstN)
		exlSet |-> !exl ##1 exl)
		else $error("stallControl: interrupt entry while exception level set");

endmodule

// File: tests/hazardVectors.svh
`ifndef HAZARD_VECTORS_SVH
`define HAZARD_VECTORS_SVH

localparam int fnAdd = 32;
localparam int numRows = 21;

localparam instrWord_t nop = '0;
localparam instrWord_t jalWord = {6'(`OP_JAL), 26'h0000040};
localparam instrWord_t eretWord = {6'(`OP_COP0), 1'b1, 19'd0, 6'(`FN_ERET)};

// pcWrite writeD writeE writeM flushD flushE flushM
localparam pipeCtrl_t ctrlIdle = 7'b0000000;
localparam pipeCtrl_t ctrlNormal = 7'b1111000;
localparam pipeCtrl_t ctrlFlushD = 7'b1111100; // Interrupt entry and eret
localparam pipeCtrl_t ctrlExecStall = 7'b0001001;
localparam pipeCtrl_t ctrlDecodeStall = 7'b0011010;

typedef struct packed {
	fwdSel_t pcReg, cmpA, cmpB, aluA, aluB, storeE, storeM;
} selSet_t;

localparam selSet_t noFwd = '0;

typedef struct packed {
	logic [3:0] group;
	instrWord_t instrD, instrE, instrM, instrW;
	logic branchOk, intReq, run;
	selSet_t expSel;
	pipeCtrl_t expCtrl;
	logic exlSet, exlClr;
} vector_t;

vector_t vectors [0:numRows-1];
int rowCount;

// Field order follows the encoding
function automatic instrWord_t addInstr(input int rs, input int rt, input int rd);
	return {6'(`OP_RTYPE), 5'(rs), 5'(rt), 5'(rd), 5'd0, 6'(fnAdd)};
endfunction

function automatic instrWord_t iInstr(input int op, input int rs, input int rt);
	return {6'(op), 5'(rs), 5'(rt), 16'h0010};
endfunction

function automatic instrWord_t jrInstr(input int rs);
	return {6'(`OP_RTYPE), 5'(rs), 15'd0, 6'(`FN_JR)};
endfunction

task automatic addRow(input logic [3:0] grp, input instrWord_t d, e, m, w,
	input logic [2:0] flags, input selSet_t sel, input pipeCtrl_t ctl, input logic [1:0] exl);
	vectors[rowCount] = {grp, d, e, m, w, flags, sel, ctl, exl};
	rowCount++;
endtask

// Flags are branchOk intReq run, exl is exlSet exlClr
task automatic loadVectors();
	rowCount = 0;
	addRow(1, nop, addInstr(1, 2, 3), addInstr(6, 7, 1), iInstr(`OP_ADDI, 8, 1), 3'b001,
		{fwdNone, fwdNone, fwdNone, fwdMAlu, fwdNone, fwdNone, fwdNone}, ctrlNormal, 2'b00);
	addRow(1, nop, addInstr(2, 1, 3), addInstr(6, 7, 1), iInstr(`OP_ADDI, 8, 2), 3'b001,
		{fwdNone, fwdNone, fwdNone, fwdWAlu, fwdMAlu, fwdNone, fwdNone}, ctrlNormal, 2'b00);
	addRow(1, nop, addInstr(31, 2, 3), jalWord, nop, 3'b001,
		{fwdNone, fwdNone, fwdNone, fwdMLink, fwdNone, fwdNone, fwdNone}, ctrlNormal, 2'b00);
	addRow(1, jrInstr(31), nop, jalWord, nop, 3'b001,
		{fwdMLink, fwdNone, fwdNone, fwdNone, fwdNone, fwdNone, fwdNone}, ctrlNormal, 2'b00);
	addRow(1, nop, iInstr(`OP_SW, 5, 9), iInstr(`OP_SW, 5, 9), iInstr(`OP_LW, 4, 9), 3'b001,
		{fwdNone, fwdNone, fwdNone, fwdNone, fwdNone, fwdWMem, fwdWMem}, ctrlNormal, 2'b00);
	addRow(2, nop, addInstr(0, 0, 3), addInstr(1, 2, 0), iInstr(`OP_ADDI, 1, 0), 3'b001,
		noFwd, ctrlNormal, 2'b00);
	addRow(2, nop, iInstr(`OP_ADDI, 1, 2), addInstr(4, 5, 2), nop, 3'b001,
		noFwd, ctrlNormal, 2'b00); // rt matches M but addi does not read it
	addRow(3, nop, addInstr(1, 2, 3), iInstr(`OP_LW, 4, 1), nop, 3'b001,
		noFwd, ctrlExecStall, 2'b00);
	addRow(3, nop, addInstr(2, 1, 3), iInstr(`OP_LW, 4, 1), nop, 3'b001,
		noFwd, ctrlExecStall, 2'b00);
	addRow(3, nop, iInstr(`OP_ADDI, 0, 1), iInstr(`OP_LW, 4, 1), nop, 3'b001,
		noFwd, ctrlNormal, 2'b00);
	addRow(4, iInstr(`OP_BEQ, 3, 5), addInstr(1, 2, 3), nop, nop, 3'b001,
		{fwdNone, fwdEAlu, fwdNone, fwdNone, fwdNone, fwdNone, fwdNone}, ctrlDecodeStall, 2'b00);
	addRow(4, iInstr(`OP_BEQ, 3, 5), nop, iInstr(`OP_LW, 4, 5), nop, 3'b001,
		noFwd, ctrlDecodeStall, 2'b00);
	addRow(4, jrInstr(3), addInstr(1, 2, 3), nop, nop, 3'b001,
		{fwdEAlu, fwdNone, fwdNone, fwdNone, fwdNone, fwdNone, fwdNone}, ctrlDecodeStall, 2'b00);
	addRow(4, iInstr(`OP_BEQ, 3, 5), nop, addInstr(1, 2, 3), addInstr(1, 2, 5), 3'b101,
		{fwdNone, fwdMAlu, fwdWAlu, fwdNone, fwdNone, fwdNone, fwdNone}, ctrlNormal, 2'b00);
	addRow(5, nop, nop, nop, nop, 3'b011, noFwd, ctrlFlushD, 2'b10);
	addRow(5, nop, nop, nop, nop, 3'b011, noFwd, ctrlNormal, 2'b00); // Flag now set
	addRow(5, eretWord, nop, nop, nop, 3'b001, noFwd, ctrlFlushD, 2'b01);
	addRow(5, nop, nop, nop, nop, 3'b011, noFwd, ctrlFlushD, 2'b10);
	addRow(6, nop, addInstr(1, 2, 3), addInstr(6, 7, 1), nop, 3'b010,
		{fwdNone, fwdNone, fwdNone, fwdMAlu, fwdNone, fwdNone, fwdNone}, ctrlIdle, 2'b00);
	addRow(6, eretWord, nop, nop, nop, 3'b000, noFwd, ctrlIdle, 2'b00);
	addRow(6, nop, addInstr(1, 2, 3), iInstr(`OP_LW, 4, 1), nop, 3'b000,
		noFwd, ctrlIdle, 2'b00);
endtask

`endif

// File: tests/hazardUnit_tb.sv
`timescale 1ns/1ps
`include "hazard_config.svh"

module hazardUnit_tb;
	import hazard_pkg::*;

	`include "hazardVectors.svh"

	localparam int resetTimeout = 20; // Cycles

	logic clk = 1'b0;
	logic rstN;
	instrWord_t instrD;
	instrWord_t instrE;
	instrWord_t instrM;
	instrWord_t instrW;
	logic branchOk;
	logic intReq;
	logic run;
	fwdSel_t selPcReg;
	fwdSel_t selCmpA;
	fwdSel_t selCmpB;
	fwdSel_t selAluA;
	fwdSel_t selAluB;
	fwdSel_t selStoreE;
	fwdSel_t selStoreM;
	pipeCtrl_t ctrl;
	logic exlSet;
	logic exlClr;

	int errors;
	int groupErrors;
	int groupRows;
	int rowsRun;
	int waited;
	logic lastOfGroup;
	string where;
	string groupName [1:6];

	hazardUnit DUT (.*);

	always #5 clk = ~clk;

	initial
	begin
		rstN = 1'b0;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;
	end

	task automatic compareValue(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp)
		else
		begin
			$display("[ERROR] %s %s: got %0h expected %0h", where, name, got, exp);
			errors++;
			groupErrors++;
		end
	endtask

	task automatic checkIdle();
		compareValue("ctrl", ctrl, ctrlIdle);
		compareValue("exlSet", exlSet, 1'b0);
		compareValue("exlClr", exlClr, 1'b0);
	endtask

	task automatic checkRow(input vector_t v);
		compareValue("selPcReg", selPcReg, v.expSel.pcReg);
		compareValue("selCmpA", selCmpA, v.expSel.cmpA);
		compareValue("selCmpB", selCmpB, v.expSel.cmpB);
		compareValue("selAluA", selAluA, v.expSel.aluA);
		compareValue("selAluB", selAluB, v.expSel.aluB);
		compareValue("selStoreE", selStoreE, v.expSel.storeE);
		compareValue("selStoreM", selStoreM, v.expSel.storeM);
		compareValue("ctrl", ctrl, v.expCtrl);
		compareValue("exlSet", exlSet, v.exlSet);
		compareValue("exlClr", exlClr, v.exlClr);
	endtask

	initial
	begin
		instrD = '0;
		instrE = '0;
		instrM = '0;
		instrW = '0;
		branchOk = 1'b0;
		intReq = 1'b0;
		run = 1'b0;
		errors = 0;
		groupErrors = 0;
		groupRows = 0;
		rowsRun = 0;
		groupName[1] = "Forwarding priority";
		groupName[2] = "Register zero and unused operands";
		groupName[3] = "Load-use stall";
		groupName[4] = "Branch and jr stall";
		groupName[5] = "Interrupt and eret sequence";
		groupName[6] = "Run low";
		loadVectors();

		where = "reset";
		waited = 0;
		while (rstN !== 1'b1)
		begin
			@(negedge clk);
			if (rstN !== 1'b1)
				checkIdle();
			waited++;
			if (waited > resetTimeout)
			begin
				$display("Timeout: reset was never released");
				$display("Simulation failed");
				$finish;
			end
		end
		$display("Run low during reset: %0d mismatches", groupErrors);
		groupErrors = 0;

		for (int i = 0; i < numRows; i++)
		begin
			@(posedge clk);
			instrD <= vectors[i].instrD;
			instrE <= vectors[i].instrE;
			instrM <= vectors[i].instrM;
			instrW <= vectors[i].instrW;
			branchOk <= vectors[i].branchOk;
			intReq <= vectors[i].intReq;
			run <= vectors[i].run;
			@(negedge clk); // Combinational outputs settled
			where = $sformatf("row %0d", i);
			checkRow(vectors[i]);
			rowsRun++;
			groupRows++;
			lastOfGroup = (i == numRows - 1) ? 1'b1 : vectors[i + 1].group != vectors[i].group;
			if (lastOfGroup)
			begin
				$display("%s: %0d rows, %0d mismatches", groupName[vectors[i].group],
					groupRows, groupErrors);
				groupRows = 0;
				groupErrors = 0;
			end
		end

		$display("Rows checked: %0d, mismatches: %0d", rowsRun, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
